// File: outbuf.f
+incdir+include
source/outbuf_pkg.sv
source/stream_fifo.sv
source/sram_sp.sv
source/mac_engine.sv
source/out_buffer.sv
source/host_reader.sv
source/outbuf_top.sv
test/outbuf_tb.sv

// File: Makefile
# Verilator flow for the result buffer
VERILATOR ?= verilator
TOP       ?= outbuf_tb
FLIST     ?= outbuf.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/1ps -Iinclude
FAIL_MSG  := Testbench failed
PASS_MSG  := Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FLIST) $(wildcard source/*.sv test/*.sv include/*.svh)
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/outbuf_tb.sv
module outbuf_tb;
  timeunit 1ns;
  timeprecision 1ps;

  // Words written plus words read over all five tests
  localparam int TOTAL_WORDS = 140;
  localparam int TOTAL_JOBS  = 7;  // Jobs over all five tests
  localparam int MAX_CYCLES  = 40 * TOTAL_WORDS + 200;
  localparam int MEM_WORDS   = 2 ** $bits(outbuf_pkg::addr_t);

  logic                clk;
  logic                rst;
  logic                job_valid_i;
  outbuf_pkg::job_t    job_i;
  logic                job_ready_o;
  logic                sample_valid_i;
  outbuf_pkg::data_t   sample_i;
  logic                sample_ready_o;
  logic                cmd_valid_i;
  outbuf_pkg::rd_cmd_t cmd_i;
  logic                cmd_ready_o;
  logic                rsp_valid_o;
  outbuf_pkg::rd_rsp_t rsp_o;
  logic                rsp_ready_i;
  logic                job_done_o;

  integer              seed = 32'h938e_9d67;
  logic [31:0]         rnd;
  outbuf_pkg::data_t   shadow [MEM_WORDS];  // Model of the SRAM contents
  outbuf_pkg::data_t   smp_buf [512];
  outbuf_pkg::rd_rsp_t exp_q [$];
  outbuf_pkg::rd_rsp_t exp_word;
  int                  done_cnt = 0;
  int                  cycle_cnt = 0;
  int                  start;
  logic                stall_mode;
  outbuf_pkg::addr_t   base;
  outbuf_pkg::data_t   coef;

  outbuf_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ========================================
  // Reference model
  // ========================================
  function automatic void model_job(input outbuf_pkg::addr_t b, input outbuf_pkg::len_t len,
                                    input outbuf_pkg::data_t c);
    outbuf_pkg::data_t acc;
    int n;
    n   = (len == '0) ? 1 : int'(len);
    acc = '0;
    for (int i = 0; i < n; i++) begin
      acc = acc + c * smp_buf[i];  // Low 32 bits of the running sum
      shadow[outbuf_pkg::addr_t'(int'(b) + i)] = acc;
    end
  endfunction

  function automatic void expect_read(input outbuf_pkg::addr_t b, input outbuf_pkg::len_t cnt);
    outbuf_pkg::rd_rsp_t w;
    int n;
    n = (cnt == '0) ? 1 : int'(cnt);
    for (int i = 0; i < n; i++) begin
      w.data = shadow[outbuf_pkg::addr_t'(int'(b) + i)];
      w.last = (i == n - 1);
      exp_q.push_back(w);
    end
  endfunction

  // ========================================
  // Checks
  // ========================================
  task automatic abort_run();
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_rsp(input outbuf_pkg::rd_rsp_t got, input outbuf_pkg::rd_rsp_t exp);
    if (got !== exp) begin
      $display("error rsp_o: got data %h last %h, expected data %h last %h",
               got.data, got.last, exp.data, exp.last);
      abort_run();
    end
  endtask

  task automatic check_done(input int got, input int exp);
    if (got != exp) begin
      $display("error job_done_o: got %h pulses, expected %h", got, exp);
      abort_run();
    end
  endtask

  always @(posedge clk) begin
    if (!rst && rsp_valid_o && rsp_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("A response word arrived while no read was outstanding");
        abort_run();
      end else begin
        exp_word = exp_q.pop_front();
        check_rsp(rsp_o, exp_word);
      end
    end
  end

  always @(posedge clk) begin
    if (!rst && job_done_o) done_cnt = done_cnt + 1;
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      abort_run();
    end
  end

  // Random stalls on the response port
  always @(negedge clk) begin
    if (rst) begin
      rsp_ready_i = 1'b0;
    end else if (stall_mode) begin
      rnd = $random(seed);
      rsp_ready_i = rnd[0];
    end else begin
      rsp_ready_i = 1'b1;
    end
  end

  // ========================================
  // Stimulus
  // ========================================
  task automatic push_sample(input outbuf_pkg::data_t s);
    @(negedge clk);
    sample_valid_i = 1'b1;
    sample_i       = s;
    @(posedge clk);
    while (!sample_ready_o) @(posedge clk);
  endtask

  task automatic run_job(input outbuf_pkg::addr_t b, input outbuf_pkg::len_t len,
                         input outbuf_pkg::data_t c);
    outbuf_pkg::job_t j;
    int n;
    n = (len == '0) ? 1 : int'(len);
    for (int i = 0; i < n; i++) smp_buf[i] = $random(seed);
    model_job(b, len, c);
    j.base = b;
    j.len  = len;
    j.coef = c;
    @(negedge clk);
    job_valid_i = 1'b1;
    job_i       = j;
    @(posedge clk);
    while (!job_ready_o) @(posedge clk);
    @(negedge clk);
    job_valid_i = 1'b0;
    for (int i = 0; i < n; i++) push_sample(smp_buf[i]);
    @(negedge clk);
    sample_valid_i = 1'b0;
  endtask

  task automatic read_range(input outbuf_pkg::addr_t b, input outbuf_pkg::len_t cnt);
    expect_read(b, cnt);
    @(negedge clk);
    cmd_valid_i = 1'b1;
    cmd_i.base  = b;
    cmd_i.count = cnt;
    @(posedge clk);
    while (!cmd_ready_o) @(posedge clk);
    @(negedge clk);
    cmd_valid_i = 1'b0;
  endtask

  task automatic wait_done(input int target);
    while (done_cnt < target) @(negedge clk);
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) @(negedge clk);
  endtask

  initial begin
    rst            = 1'b1;
    job_valid_i    = 1'b0;
    job_i          = '0;
    sample_valid_i = 1'b0;
    sample_i       = '0;
    cmd_valid_i    = 1'b0;
    cmd_i          = '0;
    rsp_ready_i    = 1'b0;
    stall_mode     = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Single job and read-back
    base  = outbuf_pkg::addr_t'($random(seed));
    coef  = $random(seed);
    start = done_cnt;
    run_job(base, outbuf_pkg::len_t'(8), coef);
    wait_done(start + 1);
    read_range(base, outbuf_pkg::len_t'(8));
    wait_drain();

    // Two jobs back to back with each sum restarting at zero
    base  = outbuf_pkg::addr_t'($random(seed));
    start = done_cnt;
    run_job(base, outbuf_pkg::len_t'(6), $random(seed));
    run_job(base + 8'd64, outbuf_pkg::len_t'(5), $random(seed));
    wait_done(start + 2);
    read_range(base, outbuf_pkg::len_t'(6));
    read_range(base + 8'd64, outbuf_pkg::len_t'(5));
    wait_drain();
    check_done(done_cnt - start, 2);

    // Read arrives while the engine owns the buffer
    base  = outbuf_pkg::addr_t'($random(seed));
    start = done_cnt;
    fork
      run_job(base, outbuf_pkg::len_t'(10), $random(seed));
      begin
        repeat (6) @(negedge clk);
        read_range(base, outbuf_pkg::len_t'(10));
      end
    join
    wait_drain();
    check_done(done_cnt - start, 1);

    // Long read with a stalling response port
    base  = outbuf_pkg::addr_t'($random(seed));
    start = done_cnt;
    run_job(base, outbuf_pkg::len_t'(32), $random(seed));
    wait_done(start + 1);
    stall_mode = 1'b1;
    read_range(base, outbuf_pkg::len_t'(32));
    wait_drain();
    stall_mode = 1'b0;

    // Zero counts and a range across the top address
    base  = outbuf_pkg::addr_t'($random(seed));
    start = done_cnt;
    run_job(base, outbuf_pkg::len_t'(0), $random(seed));
    wait_done(start + 1);
    read_range(base, outbuf_pkg::len_t'(0));
    wait_drain();
    run_job(8'hFC, outbuf_pkg::len_t'(8), $random(seed));
    wait_done(start + 2);
    read_range(8'hFC, outbuf_pkg::len_t'(8));
    wait_drain();
    repeat (10) @(negedge clk);

    // One done pulse per job over the whole run
    check_done(done_cnt, TOTAL_JOBS);
    $display("Testbench passed");
    $finish;
  end

endmodule

// File: source/outbuf_top.sv
`include "outbuf_cfg.svh"

module outbuf_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                job_valid_i,
  input  outbuf_pkg::job_t    job_i,
  output logic                job_ready_o,
  input  logic                sample_valid_i,
  input  outbuf_pkg::data_t   sample_i,
  output logic                sample_ready_o,
  input  logic                cmd_valid_i,
  input  outbuf_pkg::rd_cmd_t cmd_i,
  output logic                cmd_ready_o,
  output logic                rsp_valid_o,
  output outbuf_pkg::rd_rsp_t rsp_o,
  input  logic                rsp_ready_i,
  output logic                job_done_o
);

  logic                                   smp_valid;
  logic                                   smp_ready;
  outbuf_pkg::data_t                      smp_data;
  logic                                   eng_claim;
  logic                                   eng_valid;
  logic                                   eng_gnt;
  outbuf_pkg::wr_req_t                    eng_wr;
  logic                                   host_claim;
  logic                                   host_valid;
  logic                                   host_gnt;
  outbuf_pkg::rd_req_t                    host_rd;
  outbuf_pkg::data_t                      rd_data;
  logic                                   rsp_push;
  outbuf_pkg::rd_rsp_t                    rsp_word;
  logic [$clog2(`OUTBUF_RSP_DEPTH+1)-1:0] rsp_free;

  // ========================================
  // Producer
  // ========================================
  stream_fifo #(.T(outbuf_pkg::data_t), .DEPTH(`OUTBUF_SMP_DEPTH)) u_smp_fifo (
    .clk(clk), .rst(rst),
    .in_valid_i(sample_valid_i), .in_data_i(sample_i), .in_ready_o(sample_ready_o),
    .out_valid_o(smp_valid), .out_data_o(smp_data), .out_ready_i(smp_ready),
    .free_o()
  );

  mac_engine u_mac (
    .clk(clk), .rst(rst),
    .job_valid_i(job_valid_i), .job_i(job_i), .job_ready_o(job_ready_o),
    .smp_valid_i(smp_valid), .smp_i(smp_data), .smp_ready_o(smp_ready),
    .claim_o(eng_claim), .wr_valid_o(eng_valid), .wr_o(eng_wr), .gnt_i(eng_gnt),
    .done_o(job_done_o)
  );

  // ========================================
  // Buffer and consumer
  // ========================================
  out_buffer u_buf (
    .clk(clk), .rst(rst),
    .eng_claim_i(eng_claim), .eng_valid_i(eng_valid), .eng_wr_i(eng_wr),
    .eng_gnt_o(eng_gnt),
    .host_claim_i(host_claim), .host_valid_i(host_valid), .host_rd_i(host_rd),
    .host_gnt_o(host_gnt), .rd_data_o(rd_data)
  );

  host_reader u_reader (
    .clk(clk), .rst(rst),
    .cmd_valid_i(cmd_valid_i), .cmd_i(cmd_i), .cmd_ready_o(cmd_ready_o),
    .claim_o(host_claim), .rd_valid_o(host_valid), .rd_o(host_rd), .gnt_i(host_gnt),
    .rd_data_i(rd_data), .rsp_free_i(rsp_free),
    .rsp_valid_o(rsp_push), .rsp_o(rsp_word)
  );

  // Credits in the reader keep this FIFO from ever refusing a push
  stream_fifo #(.T(outbuf_pkg::rd_rsp_t), .DEPTH(`OUTBUF_RSP_DEPTH)) u_rsp_fifo (
    .clk(clk), .rst(rst),
    .in_valid_i(rsp_push), .in_data_i(rsp_word), .in_ready_o(),
    .out_valid_o(rsp_valid_o), .out_data_o(rsp_o), .out_ready_i(rsp_ready_i),
    .free_o(rsp_free)
  );

endmodule

// File: source/host_reader.sv
`include "outbuf_cfg.svh"

module host_reader (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic                                    cmd_valid_i,
  input  outbuf_pkg::rd_cmd_t                     cmd_i,
  output logic                                    cmd_ready_o,
  output logic                                    claim_o,
  output logic                                    rd_valid_o,
  output outbuf_pkg::rd_req_t                     rd_o,
  input  logic                                    gnt_i,
  input  outbuf_pkg::data_t                       rd_data_i,
  input  logic [$clog2(`OUTBUF_RSP_DEPTH+1)-1:0]  rsp_free_i,
  output logic                                    rsp_valid_o,
  output outbuf_pkg::rd_rsp_t                     rsp_o
);

  localparam int FREE_W = $clog2(`OUTBUF_RSP_DEPTH + 1);

  logic              run_q;
  logic              busy_q;
  outbuf_pkg::addr_t addr_q;
  outbuf_pkg::len_t  left_q;      // Reads still to issue
  logic              pipe_vld_q;  // Read issued last cycle, also the in-flight count
  logic              pipe_last_q;
  logic              has_credit;
  logic              cmd_take;
  logic              rd_take;

  // One read at most is in flight since SRAM data lands the next cycle
  assign has_credit  = rsp_free_i > FREE_W'(pipe_vld_q);
  assign cmd_ready_o = run_q && !busy_q;
  assign cmd_take    = cmd_valid_i && cmd_ready_o;
  assign claim_o     = busy_q;
  assign rd_valid_o  = busy_q && has_credit;
  assign rd_o.addr   = addr_q;
  assign rd_o.last   = (left_q == outbuf_pkg::len_t'(1));
  assign rd_take     = rd_valid_o && gnt_i;

  // Data from the SRAM paired with its last flag
  assign rsp_valid_o = pipe_vld_q;
  assign rsp_o.data  = rd_data_i;
  assign rsp_o.last  = pipe_last_q;

  // ========================================
  // Command and read issue
  // ========================================
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      run_q       <= 1'b0;
      busy_q      <= 1'b0;
      addr_q      <= '0;
      left_q      <= '0;
      pipe_vld_q  <= 1'b0;
      pipe_last_q <= 1'b0;
    end else begin
      run_q       <= 1'b1;
      pipe_vld_q  <= rd_take;
      pipe_last_q <= rd_take && rd_o.last;
      if (cmd_take) begin
        busy_q <= 1'b1;
        addr_q <= cmd_i.base;
        left_q <= (cmd_i.count == '0) ? outbuf_pkg::len_t'(1) : cmd_i.count;
      end else if (rd_take) begin
        addr_q <= addr_q + 1'b1;  // Wraps to 0 past the top
        left_q <= left_q - 1'b1;
        if (rd_o.last) busy_q <= 1'b0;
      end
    end
  end

  a_rsp_room : assert property (@(posedge clk) disable iff (rst)
    rsp_valid_o |-> rsp_free_i != '0)
    else $error("host_reader pushed a response into a full FIFO");

endmodule

// File: source/out_buffer.sv
module out_buffer (
  input  logic                clk,
  input  logic                rst,
  // Engine side writes only
  input  logic                eng_claim_i,
  input  logic                eng_valid_i,
  input  outbuf_pkg::wr_req_t eng_wr_i,
  output logic                eng_gnt_o,
  // Host side reads only
  input  logic                host_claim_i,
  input  logic                host_valid_i,
  input  outbuf_pkg::rd_req_t host_rd_i,
  output logic                host_gnt_o,
  output outbuf_pkg::data_t   rd_data_o
);

  outbuf_pkg::owner_t owner_q;
  outbuf_pkg::owner_t owner_d;

  logic               sram_en;
  logic               sram_we;
  outbuf_pkg::addr_t  sram_addr;
  outbuf_pkg::data_t  sram_wdata;

  sram_sp u_sram (
    .clk     (clk),
    .en_i    (sram_en),
    .we_i    (sram_we),
    .addr_i  (sram_addr),
    .wdata_i (sram_wdata),
    .rdata_o (rd_data_o)
  );

  // ========================================
  // Owner FSM
  // ========================================
  always_ff @(posedge clk, posedge rst) begin
    if (rst) owner_q <= outbuf_pkg::OWN_IDLE;
    else owner_q <= owner_d;
  end

  always_comb begin
    owner_d = owner_q;
    case (owner_q)
      outbuf_pkg::OWN_IDLE: begin
        if (eng_claim_i) owner_d = outbuf_pkg::OWN_ENG;  // Engine first
        else if (host_claim_i) owner_d = outbuf_pkg::OWN_HOST;
      end
      outbuf_pkg::OWN_ENG: begin
        if (eng_valid_i && eng_wr_i.last) owner_d = outbuf_pkg::OWN_IDLE;
      end
      outbuf_pkg::OWN_HOST: begin
        if (host_valid_i && host_rd_i.last) owner_d = outbuf_pkg::OWN_IDLE;
      end
      default: owner_d = outbuf_pkg::OWN_IDLE;
    endcase
  end

  assign eng_gnt_o  = (owner_q == outbuf_pkg::OWN_ENG);
  assign host_gnt_o = (owner_q == outbuf_pkg::OWN_HOST);

  // ========================================
  // SRAM port mux
  // ========================================
  always_comb begin
    sram_en    = 1'b0;
    sram_we    = 1'b0;
    sram_addr  = '0;
    sram_wdata = '0;
    case (owner_q)
      outbuf_pkg::OWN_ENG: begin
        sram_en    = eng_valid_i;
        sram_we    = 1'b1;
        sram_addr  = eng_wr_i.addr;
        sram_wdata = eng_wr_i.data;
      end
      outbuf_pkg::OWN_HOST: begin
        sram_en   = host_valid_i;
        sram_addr = host_rd_i.addr;
      end
      default: ;  // Idle keeps the port quiet
    endcase
  end

  a_one_grant : assert property (@(posedge clk) disable iff (rst)
    !(eng_gnt_o && host_gnt_o))
    else $error("out_buffer granted engine and host together");

  // Grant only goes to a side that still claims the buffer
  a_gnt_claimed : assert property (@(posedge clk) disable iff (rst)
    !(eng_gnt_o && !eng_claim_i) && !(host_gnt_o && !host_claim_i))
    else $error("out_buffer granted a side that holds no claim");

endmodule

// File: source/mac_engine.sv
module mac_engine (
  input  logic                clk,
  input  logic                rst,
  input  logic                job_valid_i,
  input  outbuf_pkg::job_t    job_i,
  output logic                job_ready_o,
  input  logic                smp_valid_i,
  input  outbuf_pkg::data_t   smp_i,
  output logic                smp_ready_o,
  output logic                claim_o,
  output logic                wr_valid_o,
  output outbuf_pkg::wr_req_t wr_o,
  input  logic                gnt_i,
  output logic                done_o
);

  logic                run_q;
  logic                busy_q;
  logic                pend_q;   // Write waiting in wr_q
  logic                done_q;
  outbuf_pkg::len_t    idx_q;
  outbuf_pkg::job_t    job_q;
  outbuf_pkg::data_t   acc_q;
  outbuf_pkg::data_t   acc_next;
  outbuf_pkg::wr_req_t wr_q;
  logic                job_take;
  logic                smp_take;
  logic                wr_take;

  assign job_ready_o = run_q && !busy_q;
  assign smp_ready_o = busy_q && gnt_i && !pend_q;
  assign job_take    = job_valid_i && job_ready_o;
  assign smp_take    = smp_valid_i && smp_ready_o;
  assign wr_take     = pend_q && gnt_i;
  assign acc_next    = acc_q + job_q.coef * smp_i;  // Low 32 bits kept

  assign claim_o    = busy_q;
  assign wr_valid_o = pend_q;
  assign wr_o       = wr_q;
  assign done_o     = done_q;

  // ========================================
  // Job control
  // ========================================
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      run_q  <= 1'b0;
      busy_q <= 1'b0;
      pend_q <= 1'b0;
      done_q <= 1'b0;
      idx_q  <= '0;
    end else begin
      run_q  <= 1'b1;
      done_q <= wr_take && wr_q.last;
      if (job_take) busy_q <= 1'b1;
      else if (wr_take && wr_q.last) busy_q <= 1'b0;
      if (smp_take) pend_q <= 1'b1;
      else if (wr_take) pend_q <= 1'b0;
      if (job_take) idx_q <= '0;
      else if (smp_take) idx_q <= idx_q + 1'b1;
    end
  end

  // Accumulator and write word
  always_ff @(posedge clk) begin
    if (job_take) begin
      job_q <= job_i;
      if (job_i.len == '0) job_q.len <= outbuf_pkg::len_t'(1);
      acc_q <= '0;
    end else if (smp_take) begin
      acc_q     <= acc_next;
      wr_q.addr <= job_q.base + outbuf_pkg::addr_t'(idx_q);  // Wraps past the top
      wr_q.data <= acc_next;
      wr_q.last <= (idx_q == job_q.len - 1'b1);
    end
  end

  a_wr_claimed : assert property (@(posedge clk) disable iff (rst)
    wr_valid_o |-> claim_o)
    else $error("mac_engine write presented without a claim");

endmodule

// File: source/sram_sp.sv
`include "outbuf_cfg.svh"

module sram_sp (
  input  logic              clk,
  input  logic              en_i,
  input  logic              we_i,
  input  outbuf_pkg::addr_t addr_i,
  input  outbuf_pkg::data_t wdata_i,
  output outbuf_pkg::data_t rdata_o
);

  localparam int WORDS = 2 ** `OUTBUF_ADDR_W;

  outbuf_pkg::data_t mem [WORDS];
  outbuf_pkg::data_t rdata_q;

  // ========================================
  // One port, write or read per cycle
  // ========================================
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) mem[addr_i] <= wdata_i;
      else rdata_q <= mem[addr_i];  // Valid next cycle
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: source/stream_fifo.sv
module stream_fifo #(
  parameter type T     = logic [31:0],
  parameter int  DEPTH = 4
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       in_valid_i,
  input  T                           in_data_i,
  output logic                       in_ready_o,
  output logic                       out_valid_o,
  output T                           out_data_o,
  input  logic                       out_ready_i,
  output logic [$clog2(DEPTH+1)-1:0] free_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  T                 mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             run_q;  // Low until the first edge after reset
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign out_valid_o = (count_q != '0);
  assign out_data_o  = mem_q[rd_ptr_q];
  // Full FIFO still takes a push when the head leaves this cycle
  assign in_ready_o  = run_q && ((count_q != CNT_W'(DEPTH)) || out_ready_i);
  assign push        = in_valid_i && in_ready_o;
  assign pop         = out_valid_o && out_ready_i;
  assign free_o      = CNT_W'(DEPTH) - count_q;

  always_ff @(posedge clk) begin
    if (push) mem_q[wr_ptr_q] <= in_data_i;
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      run_q    <= 1'b0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      run_q <= 1'b1;
      if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
      if (push && !pop) count_q <= count_q + 1'b1;
      else if (pop && !push) count_q <= count_q - 1'b1;
    end
  end

  // A word refused by a full FIFO stays offered until it is taken
  a_push_held : assert property (@(posedge clk) disable iff (rst)
    in_valid_i && !in_ready_o |=> in_valid_i && $stable(in_data_i))
    else $error("stream_fifo input word dropped before it was taken");

endmodule

// File: source/outbuf_pkg.sv
`include "outbuf_cfg.svh"

package outbuf_pkg;

  // ========================================
  // Basic words
  // ========================================
  typedef logic [`OUTBUF_DATA_W-1:0] data_t;
  typedef logic [`OUTBUF_ADDR_W-1:0] addr_t;
  typedef logic [`OUTBUF_LEN_W-1:0]  len_t;

  // ========================================
  // Stream payloads
  // ========================================
  typedef struct packed {
    addr_t base;
    len_t  len;   // Zero runs as one
    data_t coef;
  } job_t;

  typedef struct packed {
    addr_t base;
    len_t  count;
  } rd_cmd_t;

  typedef struct packed {
    addr_t addr;
    data_t data;
    logic  last;  // Releases the buffer
  } wr_req_t;

  typedef struct packed {
    addr_t addr;
    logic  last;
  } rd_req_t;

  typedef struct packed {
    data_t data;
    logic  last;
  } rd_rsp_t;

  // Who holds the SRAM port
  typedef enum logic [1:0] {
    OWN_IDLE = 2'd0,
    OWN_ENG  = 2'd1,
    OWN_HOST = 2'd2
  } owner_t;

endpackage

// File: include/outbuf_cfg.svh
`ifndef OUTBUF_CFG_SVH
`define OUTBUF_CFG_SVH

// ========================================
// Buffer geometry
// ========================================
`define OUTBUF_DATA_W    32
`define OUTBUF_ADDR_W    8   // 256 words
`define OUTBUF_LEN_W     9   // Job length or read count, up to 511

// ========================================
// Stream FIFO depths
// ========================================
`define OUTBUF_SMP_DEPTH 4
`define OUTBUF_RSP_DEPTH 4

`endif
